//--- Bender.yml
package:
  name: x86s

sources:
  - x86s_pkg.sv
  - x86s_decode.sv
  - x86s_seq.sv
  - x86s_alu.sv
  - x86s_state.sv
  - x86s_regs.sv
  - x86s_top.sv
  - target: test
    files:
      - tb_x86s.sv

//--- filelist.f
x86s_pkg.sv
x86s_decode.sv
x86s_seq.sv
x86s_alu.sv
x86s_state.sv
x86s_regs.sv
x86s_top.sv
tb_x86s.sv

//--- tb_x86s.sv
`timescale 1ns/1ps

module tb_x86s;

	localparam int N_INSN = 49;  // instructions run across all tests
	localparam int N_OTHER = 24; // loads, refused writes, unmapped probes
	localparam int N_XFERS = N_INSN * 9 + N_OTHER; // up to 9 transfers per instruction
	localparam int LIMIT_CYCLES = N_XFERS * 10 + 200;

	// expected architectural view, illegal is the sticky status bit
	typedef struct packed {
		logic [31:0] eax, esp, ebp, eip;
		logic        zf;
		logic        illegal;
	} model_t;

	logic clock_4 = 1'b0;
	logic reset;
	x86s_pkg::apb_req_t apb_req;
	x86s_pkg::apb_rsp_t apb_rsp;

	model_t m;              // running model state
	model_t got_s, exp_s;   // snapshots for the compare process
	logic busy_s;
	logic [31:0] ref_stack [16];
	logic [31:0] rng;
	int value_errors = 0;
	int protocol_errors = 0;
	event sample_ev;

	x86s_top #(
		.STACK_DEPTH (16)
	) dut_i (
		.clock_4 (clock_4),
		.reset   (reset),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	always #4 clock_4 = ~clock_4; // 8 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic [3:0] slot(input logic [31:0] addr);
		return addr[5:2]; // word index, 16 deep
	endfunction

	// opcode, modrm or rel8, imm8
	function automatic logic [31:0] enc_op(input logic [7:0] op, b1, b2);
		return {op, b1, b2, 8'h00};
	endfunction

	// immediate goes out low byte first
	function automatic logic [31:0] enc_imm24(input logic [7:0] op, input logic [23:0] imm);
		return {op, imm[7:0], imm[15:8], imm[23:16]};
	endfunction

	// one instruction on the model, steps in order
	function automatic model_t ref_exec(input model_t s, input logic [31:0] w);
		logic [7:0] op, b1, b2, b3;
		logic [31:0] rel8, imm8, imm24, rel24, r;
		model_t n;
		n = s;
		n.illegal = 1'b0;
		op = w[31:24];
		b1 = w[23:16];
		b2 = w[15:8];
		b3 = w[7:0];
		rel8 = {{24{b1[7]}}, b1};
		imm8 = {24'h0, b2};
		imm24 = {8'h0, b3, b2, b1};
		rel24 = {{8{b3[7]}}, b3, b2, b1};
		case (op)
			8'h55: begin
				n.esp = s.esp + 4; // grows up
				ref_stack[slot(n.esp)] = s.ebp;
				n.eip = s.eip + 1;
			end
			8'h5d: begin
				n.ebp = ref_stack[slot(s.esp)];
				n.esp = s.esp - 4;
				n.eip = s.eip + 1;
			end
			8'h89: begin
				n.ebp = s.esp;
				n.eip = s.eip + 2;
			end
			8'hb8: begin
				n.eax = imm24;
				n.eip = s.eip + 5;
			end
			8'h83: begin
				case (b1)
					8'hec: begin
						r = s.esp + imm8;
						n.esp = r;
						n.zf = (r == 32'h0);
						n.eip = s.eip + 3;
					end
					8'hc4: begin
						r = s.esp - imm8;
						n.esp = r;
						n.zf = (r == 32'h0);
						n.eip = s.eip + 3;
					end
					8'he8: begin
						r = s.eax - imm8;
						n.eax = r;
						n.zf = (r == 32'h0);
						n.eip = s.eip + 3;
					end
					default: n.illegal = 1'b1;
				endcase
			end
			8'heb: n.eip = s.eip + 2 + rel8;
			8'h75: n.eip = s.zf ? (s.eip + 2) : (s.eip + 2 + rel8);
			8'he8: begin
				n.esp = s.esp + 4;
				ref_stack[slot(n.esp)] = s.eip + 5; // return address
				n.eip = s.eip + 5 + rel24;
			end
			8'hc3: begin
				n.eip = ref_stack[slot(s.esp)];
				n.esp = s.esp - 4;
			end
			8'hc9: begin
				n.ebp = ref_stack[slot(s.ebp)];
				n.esp = s.ebp - 4;
				n.eip = s.eip + 1;
			end
			default: n.illegal = 1'b1;
		endcase
		return n;
	endfunction

	// called 1 ns after an edge, leaves the bus idle 1 ns after the completing edge
	task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
		input logic exp_err, output logic [31:0] rdata);
		logic err;
		apb_req.paddr = addr;
		apb_req.pwrite = wr;
		apb_req.pwdata = wdata;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(posedge clock_4);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clock_4);
		while (!apb_rsp.pready)
			@(negedge clock_4);
		rdata = apb_rsp.prdata; // stable mid cycle
		err = apb_rsp.pslverr;
		@(posedge clock_4);
		#1;
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		if (err && !exp_err) begin
			$display("unexpected pslverr on %s to address %h", wr ? "write" : "read", addr);
			protocol_errors++;
		end
		if (!err && exp_err) begin
			$display("missing pslverr on %s to address %h", wr ? "write" : "read", addr);
			protocol_errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused;
		apb_xfer(addr, 1'b1, data, exp_err, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
		apb_xfer(addr, 1'b0, 32'h0, exp_err, data);
	endtask

	task automatic load_regs(input logic [31:0] eax, esp, ebp, eip);
		apb_write(x86s_pkg::REG_EAX, eax, 1'b0);
		apb_write(x86s_pkg::REG_ESP, esp, 1'b0);
		apb_write(x86s_pkg::REG_EBP, ebp, 1'b0);
		apb_write(x86s_pkg::REG_EIP, eip, 1'b0);
		m.eax = eax;
		m.esp = esp;
		m.ebp = ebp;
		m.eip = eip;
	endtask

	// read everything back and hand it to the compare process
	task automatic compare_state();
		logic [31:0] a, sp, bp, ip, st;
		apb_read(x86s_pkg::REG_EAX, a, 1'b0);
		apb_read(x86s_pkg::REG_ESP, sp, 1'b0);
		apb_read(x86s_pkg::REG_EBP, bp, 1'b0);
		apb_read(x86s_pkg::REG_EIP, ip, 1'b0);
		apb_read(x86s_pkg::REG_STATUS, st, 1'b0);
		got_s = {a, sp, bp, ip, st[2], st[1]};
		busy_s = st[0];
		exp_s = m;
		-> sample_ev;
	endtask

	task automatic start_insn(input logic [31:0] w);
		apb_write(x86s_pkg::REG_INSN, w, 1'b0);
		apb_write(x86s_pkg::REG_CTRL, 32'h1, 1'b0);
	endtask

	task automatic finish_insn(input logic [31:0] w);
		logic [31:0] st;
		st = 32'h1;
		while (st[0]) // poll until busy drops
			apb_read(x86s_pkg::REG_STATUS, st, 1'b0);
		m = ref_exec(m, w);
		compare_state();
	endtask

	task automatic run_insn(input logic [31:0] w);
		start_insn(w);
		finish_insn(w);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] g, e);
		$display("CHECK FAILED %s got %h expected %h", name, g, e);
		value_errors++;
	endtask

	always @(sample_ev) begin
		if (got_s.eax !== exp_s.eax) report_mismatch("eax", got_s.eax, exp_s.eax);
		if (got_s.esp !== exp_s.esp) report_mismatch("esp", got_s.esp, exp_s.esp);
		if (got_s.ebp !== exp_s.ebp) report_mismatch("ebp", got_s.ebp, exp_s.ebp);
		if (got_s.eip !== exp_s.eip) report_mismatch("eip", got_s.eip, exp_s.eip);
		if (got_s.zf !== exp_s.zf) report_mismatch("zf", {31'h0, got_s.zf}, {31'h0, exp_s.zf});
		if (got_s.illegal !== exp_s.illegal)
			report_mismatch("illegal", {31'h0, got_s.illegal}, {31'h0, exp_s.illegal});
		if (busy_s !== 1'b0) report_mismatch("busy", {31'h0, busy_s}, 32'h0);
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clock_4);
		$display("timeout after %0d clock cycles, core or bus stopped responding", LIMIT_CYCLES);
		$display("errors: value %0d protocol %0d", value_errors, protocol_errors);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [31:0] r, w, rd;
		apb_req = '0;
		reset = 1'b1;
		m = '0;
		rng = 32'd45;
		for (int i = 0; i < 16; i++)
			ref_stack[i] = '0;
		repeat (16) @(posedge clock_4);
		#1;
		reset = 1'b0;

		// host loads, map holes
		load_regs(next_rand(), next_rand(), next_rand(), next_rand());
		compare_state();
		apb_read(8'h0C, rd, 1'b1);
		apb_write(8'h24, 32'h1, 1'b1);

		// refused writes while a 3 step instruction runs
		r = next_rand();
		w = enc_imm24(8'he8, r[23:0]);
		start_insn(w);
		apb_write(x86s_pkg::REG_CTRL, 32'h1, 1'b1);
		finish_insn(w);
		start_insn(32'hc9000000);
		apb_write(x86s_pkg::REG_EAX, next_rand(), 1'b1);
		finish_insn(32'hc9000000);
		r = next_rand();
		w = enc_imm24(8'he8, r[23:0]);
		start_insn(w);
		apb_write(x86s_pkg::REG_INSN, 32'h90000000, 1'b1);
		finish_insn(w);

		// mov eax and the 83 group
		r = next_rand();
		run_insn(enc_imm24(8'hb8, r[23:0]));
		r = next_rand();
		run_insn(enc_op(8'h83, 8'hec, r[7:0]));
		run_insn(enc_op(8'h83, 8'hc4, r[15:8]));
		run_insn(enc_op(8'h83, 8'he8, r[23:16]));
		r = next_rand();
		run_insn(enc_imm24(8'hb8, {16'h0, r[7:0]}));
		run_insn(enc_op(8'h83, 8'he8, r[7:0])); // lands on zero

		// push, clobber ebp, pop, then mov ebp,esp
		load_regs(next_rand(), next_rand(), next_rand(), next_rand());
		run_insn(32'h55000000);
		r = next_rand();
		apb_write(x86s_pkg::REG_EBP, r, 1'b0);
		m.ebp = r;
		run_insn(32'h5d000000);
		run_insn(32'h89e50000);

		// call and ret, then jumps
		r = next_rand();
		run_insn(enc_imm24(8'he8, r[23:0]));
		run_insn(32'hc3000000);
		for (int i = 0; i < 4; i++) begin
			r = next_rand();
			run_insn(enc_op(8'heb, r[31:24], 8'h00));
			run_insn(enc_imm24(8'hb8, {16'h0, r[7:0]}));
			run_insn(enc_op(8'h83, 8'he8, r[7:0]));          // zf set
			run_insn(enc_op(8'h75, r[15:8], 8'h00));         // falls through
			run_insn(enc_imm24(8'hb8, {16'h0, r[7:0]}));
			run_insn(enc_op(8'h83, 8'he8, r[7:0] ^ 8'h01));  // zf clear
			run_insn(enc_op(8'h75, r[23:16], 8'h00));        // taken
		end

		// frame build and teardown
		r = next_rand();
		run_insn(32'h55000000);
		run_insn(32'h89e50000);
		run_insn(enc_op(8'h83, 8'hec, r[7:0]));
		run_insn(32'hc9000000);

		// unknown encodings, then a legal one clears the flag
		run_insn(32'h90000000);
		run_insn(enc_op(8'h83, 8'h7d, 8'h10));
		r = next_rand();
		run_insn(enc_imm24(8'hb8, r[23:0]));

		repeat (2) @(posedge clock_4); // let the last compare settle
		$display("errors: value %0d protocol %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- x86s_alu.sv
`timescale 1ns/1ps

module x86s_alu (
	input  logic            clock_4,
	input  logic            reset,
	input  logic [1:0]      step,
	input  logic            busy,
	input  x86s_pkg::dec_t  cur,
	input  x86s_pkg::arch_t arch,
	output x86s_pkg::wb_t   wb
);

	logic issue;             // a real step this cycle, not the drain
	logic [31:0] op_a, op_b;
	logic sub;
	logic [31:0] res;
	logic [31:0] next_eip;   // eip past this instruction
	x86s_pkg::dst_e dst;
	logic zf_we;
	x86s_pkg::wb_t wb_d;

	assign issue = busy & (step != cur.steps);
	assign next_eip = arch.eip + {29'h0, cur.len};

	// operand and target select, by uop and step
	always_comb begin
		op_a = '0;
		op_b = '0;
		sub = 1'b0;
		dst = x86s_pkg::dst_none;
		zf_we = 1'b0;
		case (cur.uop)
			x86s_pkg::uop_push: begin
				if (step == 2'd0) begin
					op_a = arch.esp;
					op_b = x86s_pkg::STACK_STEP;
					dst = x86s_pkg::dst_esp;
				end else begin
					op_a = arch.ebp; // lands at the new esp
					dst = x86s_pkg::dst_stack;
				end
			end
			x86s_pkg::uop_pop, x86s_pkg::uop_ret: begin
				if (step == 2'd0) begin
					op_a = arch.stack_top;
					dst = (cur.uop == x86s_pkg::uop_pop) ? x86s_pkg::dst_ebp :
						x86s_pkg::dst_eip;
				end else begin
					op_a = arch.esp;
					op_b = x86s_pkg::STACK_STEP;
					sub = 1'b1;
					dst = x86s_pkg::dst_esp;
				end
			end
			x86s_pkg::uop_mov_ebp_esp: begin
				op_a = arch.esp;
				dst = x86s_pkg::dst_ebp;
			end
			x86s_pkg::uop_mov_eax: begin
				op_b = cur.imm;
				dst = x86s_pkg::dst_eax;
			end
			x86s_pkg::uop_add_esp, x86s_pkg::uop_sub_esp: begin
				op_a = arch.esp;
				op_b = cur.imm;
				sub = (cur.uop == x86s_pkg::uop_sub_esp);
				dst = x86s_pkg::dst_esp;
				zf_we = 1'b1;
			end
			x86s_pkg::uop_sub_eax: begin
				op_a = arch.eax;
				op_b = cur.imm;
				sub = 1'b1;
				dst = x86s_pkg::dst_eax;
				zf_we = 1'b1;
			end
			x86s_pkg::uop_jmp, x86s_pkg::uop_jnz: begin
				op_a = next_eip;
				// jnz falls through when zf set
				op_b = (cur.uop == x86s_pkg::uop_jnz && arch.zf) ? '0 : cur.imm;
				dst = x86s_pkg::dst_eip;
			end
			x86s_pkg::uop_call: begin
				case (step)
					2'd0: begin
						op_a = arch.esp;
						op_b = x86s_pkg::STACK_STEP;
						dst = x86s_pkg::dst_esp;
					end
					2'd1: begin
						op_a = next_eip; // return address
						dst = x86s_pkg::dst_stack;
					end
					default: begin
						op_a = next_eip;
						op_b = cur.imm;
						dst = x86s_pkg::dst_eip;
					end
				endcase
			end
			x86s_pkg::uop_leave: begin
				case (step)
					2'd0: begin
						op_a = arch.ebp;
						dst = x86s_pkg::dst_esp;
					end
					2'd1: begin
						op_a = arch.stack_top; // state forwards the pending esp
						dst = x86s_pkg::dst_ebp;
					end
					default: begin
						op_a = arch.esp;
						op_b = x86s_pkg::STACK_STEP;
						sub = 1'b1;
						dst = x86s_pkg::dst_esp;
					end
				endcase
			end
			default: ; // illegal, nothing written
		endcase
	end

	assign res = sub ? (op_a - op_b) : (op_a + op_b); // single adder

	always_comb begin
		wb_d.valid = issue & (dst != x86s_pkg::dst_none);
		wb_d.dst = dst;
		wb_d.data = res;
		wb_d.zf_we = issue & zf_we;
		wb_d.zf = (res == 32'h0);
	end

	always_ff @(posedge clock_4) begin
		if (reset)
			wb <= '0;
		else
			wb <= wb_d;
	end

endmodule

//--- x86s_decode.sv
`timescale 1ns/1ps

module x86s_decode (
	input  x86s_pkg::insn_u insn,
	output x86s_pkg::dec_t  dec
);

	logic [7:0] opcode;
	logic [31:0] imm8_zx, rel8_sx, imm24_zx, rel24_sx;

	assign opcode = insn.modrm.opcode;

	// four ways to extend the immediate, picked per opcode below
	assign imm8_zx  = {24'h0, insn.modrm.imm8};
	assign rel8_sx  = {{24{insn.imm24.b1[7]}}, insn.imm24.b1}; // byte right after opcode
	assign imm24_zx = {8'h0, insn.imm24.b3, insn.imm24.b2, insn.imm24.b1}; // little endian
	assign rel24_sx = {{8{insn.imm24.b3[7]}}, insn.imm24.b3, insn.imm24.b2, insn.imm24.b1};

	always_comb begin
		// anything unmatched stays illegal, one step, no length
		dec = '0;
		dec.uop = x86s_pkg::uop_nop_illegal;
		dec.steps = 2'd1;
		dec.illegal = 1'b1;
		case (opcode)
			8'h55: begin // push ebp
				dec.uop = x86s_pkg::uop_push;
				dec.steps = 2'd2;
				dec.len = 3'd1;
				dec.illegal = 1'b0;
			end
			8'h5d: begin // pop ebp
				dec.uop = x86s_pkg::uop_pop;
				dec.steps = 2'd2;
				dec.len = 3'd1;
				dec.illegal = 1'b0;
			end
			8'h89: begin // mov ebp,esp
				dec.uop = x86s_pkg::uop_mov_ebp_esp;
				dec.len = 3'd2;
				dec.illegal = 1'b0;
			end
			8'hb8: begin // mov eax,imm24
				dec.uop = x86s_pkg::uop_mov_eax;
				dec.len = 3'd5;
				dec.imm = imm24_zx;
				dec.illegal = 1'b0;
			end
			8'h83: begin
				dec.len = 3'd3;
				dec.imm = imm8_zx;
				dec.illegal = 1'b0;
				case (insn.modrm.modrm)
					8'hec: dec.uop = x86s_pkg::uop_add_esp; // upward stack, so +
					8'hc4: dec.uop = x86s_pkg::uop_sub_esp;
					8'he8: dec.uop = x86s_pkg::uop_sub_eax;
					default: begin // 7d and friends not handled
						dec.len = 3'd0;
						dec.imm = '0;
						dec.illegal = 1'b1;
					end
				endcase
			end
			8'heb: begin // jmp rel8
				dec.uop = x86s_pkg::uop_jmp;
				dec.len = 3'd2;
				dec.imm = rel8_sx;
				dec.illegal = 1'b0;
			end
			8'h75: begin // jnz rel8
				dec.uop = x86s_pkg::uop_jnz;
				dec.len = 3'd2;
				dec.imm = rel8_sx;
				dec.illegal = 1'b0;
			end
			8'he8: begin // call rel24
				dec.uop = x86s_pkg::uop_call;
				dec.steps = 2'd3;
				dec.len = 3'd5;
				dec.imm = rel24_sx;
				dec.illegal = 1'b0;
			end
			8'hc3: begin // ret
				dec.uop = x86s_pkg::uop_ret;
				dec.steps = 2'd2;
				dec.len = 3'd1;
				dec.illegal = 1'b0;
			end
			8'hc9: begin // leave
				dec.uop = x86s_pkg::uop_leave;
				dec.steps = 2'd3;
				dec.len = 3'd1;
				dec.illegal = 1'b0;
			end
			default: ;
		endcase
	end

endmodule

//--- x86s_pkg.sv
package x86s_pkg;

	localparam int STACK_STEP = 4; // bytes per stack word, stack grows up

	// host register map
	localparam logic [7:0] REG_INSN   = 8'h00;
	localparam logic [7:0] REG_CTRL   = 8'h04; // bit 0 go
	localparam logic [7:0] REG_STATUS = 8'h08; // busy, illegal, zf
	localparam logic [7:0] REG_EAX    = 8'h10;
	localparam logic [7:0] REG_ESP    = 8'h14;
	localparam logic [7:0] REG_EBP    = 8'h18;
	localparam logic [7:0] REG_EIP    = 8'h1C;

	typedef struct packed {
		logic [7:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// opcode / modrm / imm8 layout, used by the 83 group
	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] modrm;
		logic [7:0] imm8;
		logic [7:0] unused;
	} insn_modrm_t;

	// opcode plus three trailing bytes, immediate is b3 b2 b1
	typedef struct packed {
		logic [7:0] opcode;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
	} insn_imm24_t;

	typedef union packed {
		insn_modrm_t modrm;
		insn_imm24_t imm24;
	} insn_u;

	typedef enum logic [3:0] {
		uop_push, uop_pop, uop_mov_ebp_esp, uop_mov_eax,
		uop_add_esp, uop_sub_esp, uop_sub_eax,
		uop_jmp, uop_jnz, uop_call, uop_ret, uop_leave,
		uop_nop_illegal
	} uop_e;

	typedef struct packed {
		uop_e        uop;
		logic [1:0]  steps;   // 1 to 3
		logic [2:0]  len;     // bytes
		logic [31:0] imm;     // already extended
		logic        illegal;
	} dec_t;

	typedef enum logic [2:0] {
		dst_none, dst_eax, dst_esp, dst_ebp, dst_eip, dst_stack
	} dst_e;

	typedef struct packed {
		logic        valid;
		dst_e        dst;
		logic [31:0] data;
		logic        zf_we;
		logic        zf;
	} wb_t;

	typedef struct packed {
		logic [31:0] eax;
		logic [31:0] esp;
		logic [31:0] ebp;
		logic [31:0] eip;
		logic        zf;
		logic [31:0] stack_top; // word at esp
	} arch_t;

endpackage

//--- x86s_regs.sv
`timescale 1ns/1ps

module x86s_regs (
	input  logic               clock_4,
	input  logic               reset,
	input  x86s_pkg::apb_req_t apb_req,
	output x86s_pkg::apb_rsp_t apb_rsp,
	input  logic               busy,
	input  logic               done,
	input  logic               illegal_now,
	input  x86s_pkg::arch_t    arch,
	output x86s_pkg::insn_u    insn,
	output logic               go,
	output logic               load_we,
	output x86s_pkg::dst_e     load_dst,
	output logic [31:0]        load_data
);

	logic pready_q;   // high in the second access cycle
	logic acc;        // transfer completes this cycle
	logic wr;
	logic [7:0] addr;
	logic is_arch, mapped, err;
	logic go_bit;
	logic illegal_q;  // sticky
	logic [31:0] rdata;

	assign addr = apb_req.paddr;
	assign wr = apb_req.pwrite;
	assign go_bit = apb_req.pwdata[0];
	assign acc = apb_req.psel & apb_req.penable & pready_q;

	// one wait state
	always_ff @(posedge clock_4) begin
		if (reset)
			pready_q <= 1'b0;
		else
			pready_q <= apb_req.psel & apb_req.penable & ~pready_q;
	end

	// address decode
	always_comb begin
		is_arch = 1'b1;
		load_dst = x86s_pkg::dst_none;
		case (addr)
			x86s_pkg::REG_EAX: load_dst = x86s_pkg::dst_eax;
			x86s_pkg::REG_ESP: load_dst = x86s_pkg::dst_esp;
			x86s_pkg::REG_EBP: load_dst = x86s_pkg::dst_ebp;
			x86s_pkg::REG_EIP: load_dst = x86s_pkg::dst_eip;
			default: is_arch = 1'b0;
		endcase
	end

	assign mapped = is_arch | (addr == x86s_pkg::REG_INSN) |
		(addr == x86s_pkg::REG_CTRL) | (addr == x86s_pkg::REG_STATUS);

	// refused while the core runs, status writes are simply dropped
	assign err = ~mapped | (wr & busy & (is_arch | (addr == x86s_pkg::REG_INSN) |
		(addr == x86s_pkg::REG_CTRL && go_bit)));

	assign go = acc & wr & ~busy & (addr == x86s_pkg::REG_CTRL) & go_bit;
	assign load_we = acc & wr & ~busy & is_arch;
	assign load_data = apb_req.pwdata;

	always_ff @(posedge clock_4) begin
		if (acc && wr && !busy && addr == x86s_pkg::REG_INSN)
			insn <= apb_req.pwdata;
	end

	always_ff @(posedge clock_4) begin
		if (reset)
			illegal_q <= 1'b0;
		else if (go)
			illegal_q <= 1'b0; // cleared by the next start
		else if (done && illegal_now)
			illegal_q <= 1'b1;
	end

	// readback mux
	always_comb begin
		case (addr)
			x86s_pkg::REG_INSN:   rdata = insn;
			x86s_pkg::REG_STATUS: rdata = {29'h0, arch.zf, illegal_q, busy};
			x86s_pkg::REG_EAX:    rdata = arch.eax;
			x86s_pkg::REG_ESP:    rdata = arch.esp;
			x86s_pkg::REG_EBP:    rdata = arch.ebp;
			x86s_pkg::REG_EIP:    rdata = arch.eip;
			default:              rdata = '0; // ctrl reads as zero
		endcase
	end

	always_comb begin
		apb_rsp.pready = acc;
		apb_rsp.pslverr = acc & err;
		apb_rsp.prdata = (acc && !wr) ? rdata : '0;
	end

endmodule

//--- x86s_seq.sv
`timescale 1ns/1ps

module x86s_seq (
	input  logic            clock_4,
	input  logic            reset,
	input  logic            go,
	input  x86s_pkg::dec_t  dec,
	output logic            busy,
	output logic            done,
	output logic [1:0]      step,
	output x86s_pkg::dec_t  cur
);

	logic last; // drain cycle, last write-back sits in the alu register
	logic is_jump;

	assign last = busy & (step == cur.steps);

	// jumps write eip themselves, no advance for them
	assign is_jump = (cur.uop == x86s_pkg::uop_jmp) | (cur.uop == x86s_pkg::uop_jnz) |
		(cur.uop == x86s_pkg::uop_call) | (cur.uop == x86s_pkg::uop_ret);

	assign done = last & ~is_jump; // also the eip advance strobe

	always_ff @(posedge clock_4) begin
		if (reset) begin
			busy <= 1'b0;
			step <= 2'd0;
		end else if (go) begin
			busy <= 1'b1;
			step <= 2'd0;
		end else if (busy) begin
			if (last) begin
				busy <= 1'b0; // same edge as the final state write
				step <= 2'd0;
			end else begin
				step <= step + 2'd1;
			end
		end
	end

	// decoded word, held for the whole instruction
	always_ff @(posedge clock_4) begin
		if (go)
			cur <= dec;
	end

endmodule

//--- x86s_state.sv
`timescale 1ns/1ps

module x86s_state #(
	parameter int STACK_DEPTH = 16
) (
	input  logic            clock_4,
	input  logic            reset,
	input  x86s_pkg::wb_t   wb,
	input  logic            adv,
	input  logic [2:0]      len,
	input  logic            load_we,
	input  x86s_pkg::dst_e  load_dst,
	input  logic [31:0]     load_data,
	output x86s_pkg::arch_t arch
);

	localparam int IW = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

	logic [31:0] eax_q, esp_q, ebp_q, eip_q;
	logic zf_q;
	logic [31:0] stack_q [STACK_DEPTH];
	logic [31:0] rd_esp;
	logic [IW-1:0] rd_idx, wr_idx;

	// byte address to word slot, wraps at the depth
	function automatic logic [IW-1:0] slot(input logic [31:0] addr);
		logic [31:0] w;
		w = (addr / x86s_pkg::STACK_STEP) % STACK_DEPTH;
		return w[IW-1:0];
	endfunction

	// leave reads the stack right behind an esp write, so look through it
	assign rd_esp = (wb.valid && wb.dst == x86s_pkg::dst_esp) ? wb.data : esp_q;
	assign rd_idx = slot(rd_esp);
	assign wr_idx = slot(esp_q); // esp already settled when stack is written

	always_ff @(posedge clock_4) begin
		if (reset) begin
			eax_q <= '0;
			esp_q <= '0;
			ebp_q <= '0;
			eip_q <= '0;
			zf_q <= 1'b0;
			for (int i = 0; i < STACK_DEPTH; i++)
				stack_q[i] <= '0;
		end else begin
			if (load_we) begin // host side, only while idle
				case (load_dst)
					x86s_pkg::dst_eax: eax_q <= load_data;
					x86s_pkg::dst_esp: esp_q <= load_data;
					x86s_pkg::dst_ebp: ebp_q <= load_data;
					x86s_pkg::dst_eip: eip_q <= load_data;
					default: ;
				endcase
			end
			if (wb.valid) begin
				case (wb.dst)
					x86s_pkg::dst_eax: eax_q <= wb.data;
					x86s_pkg::dst_esp: esp_q <= wb.data;
					x86s_pkg::dst_ebp: ebp_q <= wb.data;
					x86s_pkg::dst_stack: stack_q[wr_idx] <= wb.data;
					default: ;
				endcase
			end
			// jump target wins over the length advance
			if (wb.valid && wb.dst == x86s_pkg::dst_eip)
				eip_q <= wb.data;
			else if (adv)
				eip_q <= eip_q + {29'h0, len};
			if (wb.zf_we)
				zf_q <= wb.zf;
		end
	end

	always_comb begin
		arch.eax = eax_q;
		arch.esp = esp_q;
		arch.ebp = ebp_q;
		arch.eip = eip_q;
		arch.zf = zf_q;
		arch.stack_top = stack_q[rd_idx];
	end

endmodule

//--- x86s_top.sv
`timescale 1ns/1ps

module x86s_top #(
	parameter int STACK_DEPTH = 16
) (
	input  logic               clock_4,
	input  logic               reset,
	input  x86s_pkg::apb_req_t apb_req,
	output x86s_pkg::apb_rsp_t apb_rsp
);

	x86s_pkg::insn_u  insn;
	x86s_pkg::dec_t   dec, cur;
	x86s_pkg::wb_t    wb;
	x86s_pkg::arch_t  arch;
	x86s_pkg::dst_e   load_dst;
	logic             go, busy, done, load_we;
	logic [1:0]       step;
	logic [31:0]      load_data;

	x86s_regs regs_i (
		.clock_4     (clock_4),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.busy        (busy),
		.done        (done),
		.illegal_now (cur.illegal),
		.arch        (arch),
		.insn        (insn),
		.go          (go),
		.load_we     (load_we),
		.load_dst    (load_dst),
		.load_data   (load_data)
	);

	x86s_decode decode_i (
		.insn (insn),
		.dec  (dec)
	);

	x86s_seq seq_i (
		.clock_4 (clock_4),
		.reset   (reset),
		.go      (go),
		.dec     (dec),
		.busy    (busy),
		.done    (done),
		.step    (step),
		.cur     (cur)
	);

	x86s_alu alu_i (
		.clock_4 (clock_4),
		.reset   (reset),
		.step    (step),
		.busy    (busy),
		.cur     (cur),
		.arch    (arch),
		.wb      (wb)
	);

	// done doubles as the eip advance
	x86s_state #(
		.STACK_DEPTH (STACK_DEPTH)
	) state_i (
		.clock_4   (clock_4),
		.reset     (reset),
		.wb        (wb),
		.adv       (done),
		.len       (cur.len),
		.load_we   (load_we),
		.load_dst  (load_dst),
		.load_data (load_data),
		.arch      (arch)
	);

endmodule
